//--- hdl/ooo_params.svh
// Core sizes, Alpha opcode and function encodings, halt status codes
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

`define OOO_XLEN      64
`define OOO_NUM_AR    32
`define OOO_NUM_PR    64
`define OOO_PR_W      6
`define OOO_AR_W      5
`define OOO_ROB_DEPTH 16
`define OOO_ROB_W     4
`define OOO_RS_DEPTH  8
`define OOO_ZERO_REG  5'd31

// Operate format opcodes
`define OOO_OP_PAL  6'h00
`define OOO_OP_INTA 6'h10
`define OOO_OP_INTL 6'h11
`define OOO_OP_INTS 6'h12

`define OOO_FN_ADDQ   7'h20 // INTA
`define OOO_FN_SUBQ   7'h29
`define OOO_FN_CMPEQ  7'h2d
`define OOO_FN_CMPULT 7'h1d
`define OOO_FN_AND    7'h00 // INTL
`define OOO_FN_BIS    7'h20
`define OOO_FN_XOR    7'h40
`define OOO_FN_SLL    7'h39 // INTS
`define OOO_FN_SRL    7'h34

`define OOO_STATUS_W          4
`define OOO_NO_ERROR          4'h0
`define OOO_HALTED_ON_HALT    4'h2
`define OOO_HALTED_ON_ILLEGAL 4'h3

`endif

//--- hdl/ooo_pkg.sv
// Instruction word views, ALU function enum, decoded op, issue, CDB and commit structs
`default_nettype none
`include "ooo_params.svh"

package ooo_pkg;

	// Register form of the operate format
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [2:0] sbz;
		logic       is_lit;
		logic [6:0] func;
		logic [4:0] rc;
	} opr_reg_t;

	// Literal form with the 8-bit literal in bits 20:13
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] ra;
		logic [7:0] lit;
		logic       is_lit;
		logic [6:0] func;
		logic [4:0] rc;
	} opr_lit_t;

	typedef union packed {
		opr_reg_t reg_view;
		opr_lit_t lit_view;
	} alpha_inst_t;

	typedef enum logic [3:0] {
		ALU_ADDQ,
		ALU_SUBQ,
		ALU_CMPEQ,
		ALU_CMPULT,
		ALU_AND,
		ALU_BIS,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL
	} alu_func_t;

	typedef struct packed {
		logic [`OOO_AR_W-1:0] ra_idx;
		logic [`OOO_AR_W-1:0] rb_idx;
		logic [`OOO_AR_W-1:0] dest_idx;
		logic                 use_literal;
		logic [7:0]           literal;
		alu_func_t            func;
		logic                 has_dest;
		logic                 halt;
		logic                 illegal;
	} decoded_t;

	typedef struct packed {
		alu_func_t             func;
		logic [`OOO_PR_W-1:0]  a_tag;
		logic [`OOO_PR_W-1:0]  b_tag;
		logic                  use_literal;
		logic [7:0]            literal;
		logic [`OOO_PR_W-1:0]  dest_tag;
		logic [`OOO_ROB_W-1:0] rob_idx;
	} issue_t;

	typedef struct packed {
		logic                  valid;
		logic [`OOO_PR_W-1:0]  tag;
		logic [`OOO_ROB_W-1:0] rob_idx;
		logic [`OOO_XLEN-1:0]  value;
	} cdb_t;

	typedef struct packed {
		logic                 wr_en;
		logic [`OOO_AR_W-1:0] idx;
		logic [`OOO_XLEN-1:0] data;
	} commit_t;

endpackage

`default_nettype wire

//--- hdl/decoder.sv
// Operate-format decoder for one Alpha instruction word
`default_nettype none
`include "ooo_params.svh"

module decoder (
	input  ooo_pkg::alpha_inst_t inst,
	output ooo_pkg::decoded_t    dec
);

	always_comb begin
		dec = '0;
		dec.ra_idx = inst.reg_view.ra;
		dec.dest_idx = inst.reg_view.rc;
		dec.use_literal = inst.reg_view.is_lit;
		if (inst.reg_view.is_lit) begin
			dec.literal = inst.lit_view.lit;
		end else begin
			dec.rb_idx = inst.reg_view.rb;
			if (inst.reg_view.sbz != 3'b000)
				dec.illegal = 1'b1; // Must-be-zero field
		end

		case (inst.reg_view.opcode)
			`OOO_OP_INTA: case (inst.reg_view.func)
				`OOO_FN_ADDQ:   dec.func = ooo_pkg::ALU_ADDQ;
				`OOO_FN_SUBQ:   dec.func = ooo_pkg::ALU_SUBQ;
				`OOO_FN_CMPEQ:  dec.func = ooo_pkg::ALU_CMPEQ;
				`OOO_FN_CMPULT: dec.func = ooo_pkg::ALU_CMPULT;
				default:        dec.illegal = 1'b1;
			endcase
			`OOO_OP_INTL: case (inst.reg_view.func)
				`OOO_FN_AND: dec.func = ooo_pkg::ALU_AND;
				`OOO_FN_BIS: dec.func = ooo_pkg::ALU_BIS;
				`OOO_FN_XOR: dec.func = ooo_pkg::ALU_XOR;
				default:     dec.illegal = 1'b1;
			endcase
			`OOO_OP_INTS: case (inst.reg_view.func)
				`OOO_FN_SLL: dec.func = ooo_pkg::ALU_SLL;
				`OOO_FN_SRL: dec.func = ooo_pkg::ALU_SRL;
				default:     dec.illegal = 1'b1;
			endcase
			`OOO_OP_PAL: begin
				if (inst == '0)
					dec.halt = 1'b1;
				else
					dec.illegal = 1'b1; // Other PAL calls unsupported
			end
			default: dec.illegal = 1'b1;
		endcase

		// Writes to r31 are discarded
		dec.has_dest = !dec.halt && !dec.illegal && (inst.reg_view.rc != `OOO_ZERO_REG);
	end

endmodule

`default_nettype wire

//--- hdl/rename_unit.sv
// Register rename: map table and FIFO free list of physical tags
`default_nettype none
`include "ooo_params.svh"

module rename_unit (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 dispatch,
	input  ooo_pkg::decoded_t    dec,
	output logic [`OOO_PR_W-1:0] src_a_tag,
	output logic [`OOO_PR_W-1:0] src_b_tag,
	output logic [`OOO_PR_W-1:0] dest_tag,
	output logic [`OOO_PR_W-1:0] old_tag,
	output logic                 free_empty,
	input  logic                 retire_free,
	input  logic [`OOO_PR_W-1:0] retire_tag
);

	localparam int PR_W = `OOO_PR_W;
	localparam int NUM_AR = `OOO_NUM_AR;
	localparam int FL_DEPTH = `OOO_NUM_PR - `OOO_NUM_AR;
	localparam int FL_W = $clog2(FL_DEPTH);

	logic [PR_W-1:0] map_table [NUM_AR];
	logic [PR_W-1:0] free_fifo [FL_DEPTH];
	logic [FL_W-1:0] free_head;
	logic [FL_W-1:0] free_tail;
	logic [FL_W:0]   free_count;
	logic            pop;

	assign pop = dispatch && dec.has_dest;

	assign src_a_tag = map_table[dec.ra_idx];
	assign src_b_tag = map_table[dec.rb_idx];
	assign old_tag = map_table[dec.dest_idx];
	assign dest_tag = free_fifo[free_head]; // Next free tag
	assign free_empty = (free_count == '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_AR; i++)
				map_table[i] <= PR_W'(i); // Identity mapping
			for (int i = 0; i < FL_DEPTH; i++)
				free_fifo[i] <= PR_W'(i + NUM_AR);
			free_head <= '0;
			free_tail <= '0;
			free_count <= (FL_W + 1)'(FL_DEPTH);
		end else begin
			if (pop) begin
				map_table[dec.dest_idx] <= dest_tag;
				free_head <= free_head + 1'b1;
			end
			if (retire_free) begin
				free_fifo[free_tail] <= retire_tag; // Previous mapping is dead now
				free_tail <= free_tail + 1'b1;
			end
			free_count <= free_count + {{FL_W{1'b0}}, retire_free} - {{FL_W{1'b0}}, pop};
		end
	end

	// Dispatch must hold off when no tag is left
	a_no_pop_when_empty: assert property (@(posedge clock) disable iff (reset)
		pop |-> !free_empty);

endmodule

`default_nettype wire

//--- hdl/rob.sv
// Reorder buffer with in-order retire and halt status capture
`default_nettype none
`include "ooo_params.svh"

module rob (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     alloc,
	input  logic [`OOO_AR_W-1:0]     alloc_dest_idx,
	input  logic                     alloc_has_dest,
	input  logic [`OOO_PR_W-1:0]     alloc_dest_tag,
	input  logic [`OOO_PR_W-1:0]     alloc_old_tag,
	input  logic                     alloc_halt,
	input  logic                     alloc_illegal,
	output logic [`OOO_ROB_W-1:0]    tail_idx,
	output logic                     full,
	input  ooo_pkg::cdb_t            cdb,
	output logic                     commit_valid,
	output logic [`OOO_PR_W-1:0]     commit_tag,
	input  logic [`OOO_XLEN-1:0]     commit_value,
	output ooo_pkg::commit_t         commit,
	output logic                     retire_free,
	output logic [`OOO_PR_W-1:0]     retire_tag,
	output logic [`OOO_STATUS_W-1:0] stop_code
);

	localparam int DEPTH = `OOO_ROB_DEPTH;
	localparam int ROB_W = `OOO_ROB_W;

	typedef struct packed {
		logic                 has_dest;
		logic [`OOO_AR_W-1:0] dest_idx;
		logic [`OOO_PR_W-1:0] dest_tag;
		logic [`OOO_PR_W-1:0] old_tag;
		logic                 halt;
		logic                 illegal;
	} rob_entry_t;

	rob_entry_t       entry [DEPTH];
	logic [DEPTH-1:0] valid;
	logic [DEPTH-1:0] done;
	logic [ROB_W-1:0] head;
	logic [ROB_W-1:0] tail;
	logic [ROB_W:0]   count;

	assign tail_idx = tail;
	assign full = (count == (ROB_W + 1)'(DEPTH));
	assign commit_valid = valid[head] && done[head];
	assign commit_tag = entry[head].dest_tag;
	assign retire_free = commit_valid && entry[head].has_dest;
	assign retire_tag = entry[head].old_tag;

	always_comb begin
		commit.wr_en = retire_free;
		commit.idx = entry[head].dest_idx;
		commit.data = entry[head].has_dest ? commit_value : '0;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
			done <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
			stop_code <= `OOO_NO_ERROR;
		end else begin
			if (alloc) begin
				valid[tail] <= 1'b1;
				done[tail] <= !alloc_has_dest; // Nothing to wait for
				tail <= tail + 1'b1;
			end
			if (cdb.valid)
				done[cdb.rob_idx] <= 1'b1;
			if (commit_valid) begin
				valid[head] <= 1'b0;
				head <= head + 1'b1;
				if (entry[head].halt)
					stop_code <= `OOO_HALTED_ON_HALT;
				else if (entry[head].illegal)
					stop_code <= `OOO_HALTED_ON_ILLEGAL;
			end
			count <= count + {{ROB_W{1'b0}}, alloc} - {{ROB_W{1'b0}}, commit_valid};
		end
	end

	always_ff @(posedge clock) begin
		if (alloc)
			entry[tail] <= '{alloc_has_dest, alloc_dest_idx, alloc_dest_tag,
				alloc_old_tag, alloc_halt, alloc_illegal};
	end

	// Results only come back for live, unfinished entries
	a_cdb_hits_live_entry: assert property (@(posedge clock) disable iff (reset)
		cdb.valid |-> valid[cdb.rob_idx] && !done[cdb.rob_idx]);

endmodule

`default_nettype wire

//--- hdl/reservation_station.sv
// Reservation station with CDB wakeup and lowest-index select
`default_nettype none
`include "ooo_params.svh"

module reservation_station (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  dispatch,
	input  ooo_pkg::decoded_t     dec,
	input  logic [`OOO_PR_W-1:0]  src_a_tag,
	input  logic [`OOO_PR_W-1:0]  src_b_tag,
	input  logic [`OOO_PR_W-1:0]  dest_tag,
	input  logic                  src_a_ready,
	input  logic                  src_b_ready,
	input  logic [`OOO_ROB_W-1:0] rob_idx,
	input  ooo_pkg::cdb_t         cdb,
	output logic                  full,
	output logic                  issue_valid,
	output ooo_pkg::issue_t       issue
);

	localparam int DEPTH = `OOO_RS_DEPTH;
	localparam int IDX_W = $clog2(DEPTH);

	ooo_pkg::issue_t  slot [DEPTH];
	logic [DEPTH-1:0] valid;
	logic [DEPTH-1:0] a_rdy;
	logic [DEPTH-1:0] b_rdy;
	logic [IDX_W-1:0] alloc_idx;
	logic [IDX_W-1:0] issue_idx;
	logic             alloc;

	// Ops without a destination complete in the ROB
	assign alloc = dispatch && dec.has_dest;
	assign full = &valid;

	always_comb begin
		alloc_idx = '0;
		issue_idx = '0;
		issue_valid = 1'b0;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (!valid[i])
				alloc_idx = IDX_W'(i);
			if (valid[i] && a_rdy[i] && b_rdy[i]) begin
				issue_idx = IDX_W'(i);
				issue_valid = 1'b1;
			end
		end
	end

	assign issue = slot[issue_idx];

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
			a_rdy <= '0;
			b_rdy <= '0;
		end else begin
			for (int i = 0; i < DEPTH; i++) begin
				if (cdb.valid && valid[i]) begin
					if (slot[i].a_tag == cdb.tag)
						a_rdy[i] <= 1'b1;
					if (slot[i].b_tag == cdb.tag)
						b_rdy[i] <= 1'b1;
				end
			end
			if (issue_valid)
				valid[issue_idx] <= 1'b0;
			if (alloc) begin
				valid[alloc_idx] <= 1'b1;
				a_rdy[alloc_idx] <= src_a_ready;
				b_rdy[alloc_idx] <= src_b_ready || dec.use_literal; // Literal needs no tag
			end
		end
	end

	always_ff @(posedge clock) begin
		if (alloc)
			slot[alloc_idx] <= '{dec.func, src_a_tag, src_b_tag, dec.use_literal,
				dec.literal, dest_tag, rob_idx};
	end

	// Top level stalls dispatch on full
	a_no_alloc_when_full: assert property (@(posedge clock) disable iff (reset)
		alloc |-> !full);

endmodule

`default_nettype wire

//--- hdl/prf.sv
// Physical register file with busy bits, operand and retire read ports
`default_nettype none
`include "ooo_params.svh"

module prf (
	input  logic                 clock,
	input  logic                 reset,
	input  ooo_pkg::issue_t      issue,
	output logic [`OOO_XLEN-1:0] opa,
	output logic [`OOO_XLEN-1:0] opb,
	input  logic [`OOO_PR_W-1:0] busy_query_a,
	input  logic [`OOO_PR_W-1:0] busy_query_b,
	output logic                 ready_a,
	output logic                 ready_b,
	input  logic                 set_busy,
	input  logic [`OOO_PR_W-1:0] set_busy_tag,
	input  ooo_pkg::cdb_t        cdb,
	input  logic [`OOO_PR_W-1:0] retire_tag,
	output logic [`OOO_XLEN-1:0] retire_value
);

	localparam int NUM_PR = `OOO_NUM_PR;

	logic [`OOO_XLEN-1:0] value [NUM_PR];
	logic [NUM_PR-1:0]    busy;

	assign opa = value[issue.a_tag];
	assign opb = value[issue.b_tag];
	assign retire_value = value[retire_tag];

	// Same-cycle broadcast counts as ready
	assign ready_a = !busy[busy_query_a] || (cdb.valid && cdb.tag == busy_query_a);
	assign ready_b = !busy[busy_query_b] || (cdb.valid && cdb.tag == busy_query_b);

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_PR; i++) begin
				value[i] <= '0;
				busy[i] <= (i >= `OOO_NUM_AR); // Only the identity-mapped tags hold values
			end
		end else begin
			if (cdb.valid) begin
				value[cdb.tag] <= cdb.value;
				busy[cdb.tag] <= 1'b0;
			end
			if (set_busy)
				busy[set_busy_tag] <= 1'b1;
		end
	end

	// A result only lands in a tag that was handed out by rename
	a_cdb_tag_busy: assert property (@(posedge clock) disable iff (reset)
		cdb.valid |-> busy[cdb.tag]);

endmodule

`default_nettype wire

//--- hdl/int_alu.sv
// Single-cycle integer ALU registered onto the CDB
`default_nettype none
`include "ooo_params.svh"

module int_alu (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 issue_valid,
	input  ooo_pkg::issue_t      issue,
	input  logic [`OOO_XLEN-1:0] opa,
	input  logic [`OOO_XLEN-1:0] opb,
	output ooo_pkg::cdb_t        cdb
);

	localparam int XLEN = `OOO_XLEN;

	logic [XLEN-1:0] b;
	logic [XLEN-1:0] result;

	assign b = issue.use_literal ? {{(XLEN - 8){1'b0}}, issue.literal} : opb;

	always_comb begin
		case (issue.func)
			ooo_pkg::ALU_ADDQ:   result = opa + b;
			ooo_pkg::ALU_SUBQ:   result = opa - b;
			ooo_pkg::ALU_CMPEQ:  result = XLEN'(opa == b);
			ooo_pkg::ALU_CMPULT: result = XLEN'(opa < b);
			ooo_pkg::ALU_AND:    result = opa & b;
			ooo_pkg::ALU_BIS:    result = opa | b;
			ooo_pkg::ALU_XOR:    result = opa ^ b;
			ooo_pkg::ALU_SLL:    result = opa << b[5:0];
			ooo_pkg::ALU_SRL:    result = opa >> b[5:0]; // Logical
			default:             result = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			cdb.valid <= 1'b0;
		else
			cdb.valid <= issue_valid;
		cdb.tag <= issue.dest_tag;
		cdb.rob_idx <= issue.rob_idx;
		cdb.value <= result;
	end

endmodule

`default_nettype wire

//--- hdl/pipeline.sv
// Core top: dispatch handshake, rename, ROB, RS, PRF, ALU and CDB
`default_nettype none
`include "ooo_params.svh"

module pipeline (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     inst_valid,
	input  ooo_pkg::alpha_inst_t     inst,
	output logic                     inst_ready,
	output logic                     commit_valid,
	output ooo_pkg::commit_t         commit,
	output logic [`OOO_STATUS_W-1:0] error_status
);

	ooo_pkg::decoded_t     dec;
	ooo_pkg::issue_t       issue;
	ooo_pkg::cdb_t         cdb;
	logic                  dispatch;
	logic                  started;
	logic                  halted;
	logic [`OOO_PR_W-1:0]  src_a_tag;
	logic [`OOO_PR_W-1:0]  src_b_tag;
	logic [`OOO_PR_W-1:0]  dest_tag;
	logic [`OOO_PR_W-1:0]  old_tag;
	logic                  free_empty;
	logic                  retire_free;
	logic [`OOO_PR_W-1:0]  retire_tag;
	logic [`OOO_ROB_W-1:0] rob_tail;
	logic                  rob_full;
	logic                  rs_full;
	logic [`OOO_PR_W-1:0]  commit_tag;
	logic [`OOO_XLEN-1:0]  commit_value;
	logic                  issue_valid;
	logic [`OOO_XLEN-1:0]  opa;
	logic [`OOO_XLEN-1:0]  opb;
	logic                  ready_a;
	logic                  ready_b;

	assign inst_ready = started && !halted && !rob_full && !rs_full
		&& (!free_empty || !dec.has_dest);
	assign dispatch = inst_valid && inst_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			started <= 1'b0;
			halted <= 1'b0;
		end else begin
			started <= 1'b1;
			if (dispatch && (dec.halt || dec.illegal))
				halted <= 1'b1; // No fetch past a stop
		end
	end

	decoder id0 (.inst(inst), .dec(dec));

	rename_unit rename0 (.clock(clock), .reset(reset), .dispatch(dispatch), .dec(dec),
		.src_a_tag(src_a_tag), .src_b_tag(src_b_tag), .dest_tag(dest_tag),
		.old_tag(old_tag), .free_empty(free_empty), .retire_free(retire_free),
		.retire_tag(retire_tag));

	rob rob0 (.clock(clock), .reset(reset), .alloc(dispatch),
		.alloc_dest_idx(dec.dest_idx), .alloc_has_dest(dec.has_dest),
		.alloc_dest_tag(dest_tag), .alloc_old_tag(old_tag), .alloc_halt(dec.halt),
		.alloc_illegal(dec.illegal), .tail_idx(rob_tail), .full(rob_full), .cdb(cdb),
		.commit_valid(commit_valid), .commit_tag(commit_tag),
		.commit_value(commit_value), .commit(commit), .retire_free(retire_free),
		.retire_tag(retire_tag), .stop_code(error_status));

	reservation_station rs0 (.clock(clock), .reset(reset), .dispatch(dispatch), .dec(dec),
		.src_a_tag(src_a_tag), .src_b_tag(src_b_tag), .dest_tag(dest_tag),
		.src_a_ready(ready_a), .src_b_ready(ready_b), .rob_idx(rob_tail), .cdb(cdb),
		.full(rs_full), .issue_valid(issue_valid), .issue(issue));

	prf prf0 (.clock(clock), .reset(reset), .issue(issue), .opa(opa), .opb(opb),
		.busy_query_a(src_a_tag), .busy_query_b(src_b_tag), .ready_a(ready_a),
		.ready_b(ready_b), .set_busy(dispatch && dec.has_dest), .set_busy_tag(dest_tag),
		.cdb(cdb), .retire_tag(commit_tag), .retire_value(commit_value));

	int_alu alu0 (.clock(clock), .reset(reset), .issue_valid(issue_valid), .issue(issue),
		.opa(opa), .opb(opb), .cdb(cdb));

endmodule

`default_nettype wire

//--- tb/pipeline_tb.sv
// Testbench for the pipeline: clock, reset, architectural register model, directed tests
`default_nettype none
`include "ooo_params.svh"

module pipeline_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 200;

	logic                     clock;
	logic                     reset;
	logic                     inst_valid;
	ooo_pkg::alpha_inst_t     inst;
	logic                     inst_ready;
	logic                     commit_valid;
	ooo_pkg::commit_t         commit;
	logic [`OOO_STATUS_W-1:0] error_status;

	logic [63:0]      arch [32];
	ooo_pkg::commit_t expect_q [$];
	int               seed;
	int               err_count;
	int               test_count;
	int               sent_count;
	int               commit_count;
	int               stall_count;

	pipeline dut0 (.clock(clock), .reset(reset), .inst_valid(inst_valid), .inst(inst),
		.inst_ready(inst_ready), .commit_valid(commit_valid), .commit(commit),
		.error_status(error_status));

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// Retire checker sampled mid-cycle
	always @(negedge clock) begin : retire_check
		ooo_pkg::commit_t exp;
		if (commit_valid) begin
			commit_count++;
			if (error_status !== `OOO_NO_ERROR) begin
				$display("ERR error_status at commit: got %h expected %h", error_status,
					`OOO_NO_ERROR);
				err_count++;
			end
			if (expect_q.size() == 0) begin
				$display("commit seen with no instruction outstanding");
				err_count++;
			end else begin
				exp = expect_q.pop_front();
				if (commit.wr_en !== exp.wr_en) begin
					$display("ERR commit.wr_en: got %h expected %h", commit.wr_en, exp.wr_en);
					err_count++;
				end
				if (commit.idx !== exp.idx) begin
					$display("ERR commit.idx: got %h expected %h", commit.idx, exp.idx);
					err_count++;
				end
				if (exp.wr_en && commit.data !== exp.data) begin
					$display("ERR commit.data: got %h expected %h", commit.data, exp.data);
					err_count++;
				end
			end
		end
	end

	function automatic ooo_pkg::alpha_inst_t reg_form(input logic [5:0] opc,
		input logic [6:0] fn, input logic [4:0] ra, input logic [4:0] rb, input logic [4:0] rc);
		ooo_pkg::alpha_inst_t w;
		w = '0;
		w.reg_view.opcode = opc;
		w.reg_view.ra = ra;
		w.reg_view.rb = rb;
		w.reg_view.func = fn;
		w.reg_view.rc = rc;
		return w;
	endfunction

	function automatic ooo_pkg::alpha_inst_t lit_form(input logic [5:0] opc,
		input logic [6:0] fn, input logic [4:0] ra, input logic [7:0] lit, input logic [4:0] rc);
		ooo_pkg::alpha_inst_t w;
		w = '0;
		w.lit_view.opcode = opc;
		w.lit_view.ra = ra;
		w.lit_view.lit = lit;
		w.lit_view.is_lit = 1'b1;
		w.lit_view.func = fn;
		w.lit_view.rc = rc;
		return w;
	endfunction

	function automatic logic [7:0] rand_byte();
		return 8'($random(seed));
	endfunction

	// Architectural effect of one instruction in program order
	task automatic model_apply(input ooo_pkg::alpha_inst_t w);
		ooo_pkg::commit_t exp;
		logic [63:0]      a;
		logic [63:0]      b;
		logic [63:0]      r;
		logic             legal;
		a = arch[w.reg_view.ra];
		b = w.reg_view.is_lit ? 64'(w.lit_view.lit) : arch[w.reg_view.rb];
		legal = w.reg_view.is_lit || (w.reg_view.sbz == 3'b000);
		r = '0;
		case ({w.reg_view.opcode, w.reg_view.func})
			{`OOO_OP_INTA, `OOO_FN_ADDQ}:   r = a + b;
			{`OOO_OP_INTA, `OOO_FN_SUBQ}:   r = a - b;
			{`OOO_OP_INTA, `OOO_FN_CMPEQ}:  r = 64'(a == b);
			{`OOO_OP_INTA, `OOO_FN_CMPULT}: r = 64'(a < b);
			{`OOO_OP_INTL, `OOO_FN_AND}:    r = a & b;
			{`OOO_OP_INTL, `OOO_FN_BIS}:    r = a | b;
			{`OOO_OP_INTL, `OOO_FN_XOR}:    r = a ^ b;
			{`OOO_OP_INTS, `OOO_FN_SLL}:    r = a << b[5:0];
			{`OOO_OP_INTS, `OOO_FN_SRL}:    r = a >> b[5:0];
			default:                        legal = 1'b0; // HALT lands here too
		endcase
		exp.wr_en = legal && (w.reg_view.rc != 5'd31);
		exp.idx = w.reg_view.rc;
		exp.data = exp.wr_en ? r : '0;
		if (exp.wr_en)
			arch[w.reg_view.rc] = r;
		expect_q.push_back(exp);
	endtask

	task automatic send(input ooo_pkg::alpha_inst_t w);
		int waited;
		waited = 0;
		@(negedge clock);
		inst = w;
		inst_valid = 1'b1;
		#1;
		while (!inst_ready && waited < TIMEOUT) begin
			@(negedge clock);
			#1;
			waited++;
		end
		stall_count += waited;
		if (!inst_ready) begin
			$display("timeout: instruction %h was never accepted", w);
			err_count++;
		end else begin
			model_apply(w);
			sent_count++;
			@(posedge clock); // Transfer edge
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		@(negedge clock);
		inst_valid = 1'b0;
		#1;
		while (expect_q.size() != 0 && waited < TIMEOUT) begin
			@(negedge clock);
			#1;
			waited++;
		end
		if (expect_q.size() != 0) begin
			$display("timeout: %0d commits still outstanding", expect_q.size());
			err_count++;
			expect_q.delete();
		end
	endtask

	task automatic apply_reset();
		@(negedge clock);
		reset = 1'b1;
		inst_valid = 1'b0;
		repeat (4) @(negedge clock);
		if (inst_ready !== 1'b0 || commit_valid !== 1'b0) begin
			$display("ERR inst_ready/commit_valid in reset: got %h/%h expected 0/0",
				inst_ready, commit_valid);
			err_count++;
		end
		if (error_status !== `OOO_NO_ERROR) begin
			$display("ERR error_status: got %h expected %h", error_status, `OOO_NO_ERROR);
			err_count++;
		end
		reset = 1'b0;
		for (int i = 0; i < 32; i++)
			arch[i] = '0;
		expect_q.delete();
	endtask

	task automatic wait_status(input logic [`OOO_STATUS_W-1:0] code);
		int waited;
		waited = 0;
		while (error_status !== code && waited < TIMEOUT) begin
			@(negedge clock);
			waited++;
		end
		if (error_status !== code) begin
			$display("ERR error_status: got %h expected %h", error_status, code);
			err_count++;
		end
	endtask

	// Core must refuse a legal word once stopped
	task automatic check_stalled();
		@(negedge clock);
		inst = lit_form(`OOO_OP_INTL, `OOO_FN_BIS, 5'd31, 8'h11, 5'd1);
		inst_valid = 1'b1;
		repeat (5) begin
			#1;
			if (inst_ready !== 1'b0) begin
				$display("ERR inst_ready: got %h expected 0", inst_ready);
				err_count++;
			end
			@(negedge clock);
		end
		inst_valid = 1'b0;
	endtask

	task automatic finish_test(input string name, input int errs_before);
		test_count++;
		if (err_count == errs_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, err_count - errs_before);
	endtask

	task automatic literal_loads();
		int errs;
		errs = err_count;
		for (int i = 0; i < 10; i++)
			send(lit_form(`OOO_OP_INTL, `OOO_FN_BIS, 5'd31, rand_byte(), 5'(i + 1)));
		drain();
		finish_test("literal_loads", errs);
	endtask

	task automatic dependent_chain();
		int errs;
		errs = err_count;
		for (int k = 0; k < 3; k++) begin
			send(lit_form(`OOO_OP_INTL, `OOO_FN_BIS, 5'd31, rand_byte(), 5'd1));
			send(lit_form(`OOO_OP_INTL, `OOO_FN_BIS, 5'd31, rand_byte(), 5'd2));
			send(lit_form(`OOO_OP_INTS, `OOO_FN_SLL, 5'd1, 8'(32 + k), 5'd1)); // Wide value
			send(reg_form(`OOO_OP_INTA, `OOO_FN_ADDQ, 5'd1, 5'd2, 5'd3));
			send(reg_form(`OOO_OP_INTA, `OOO_FN_SUBQ, 5'd3, 5'd2, 5'd4));
			send(reg_form(`OOO_OP_INTA, `OOO_FN_CMPEQ, 5'd4, 5'd1, 5'd6));
			send(reg_form(`OOO_OP_INTA, `OOO_FN_CMPULT, 5'd2, 5'd3, 5'd7));
			send(reg_form(`OOO_OP_INTA, `OOO_FN_CMPULT, 5'd3, 5'd2, 5'd8));
			send(reg_form(`OOO_OP_INTL, `OOO_FN_AND, 5'd3, 5'd4, 5'd9));
			send(reg_form(`OOO_OP_INTL, `OOO_FN_XOR, 5'd9, 5'd2, 5'd10));
			send(reg_form(`OOO_OP_INTS, `OOO_FN_SLL, 5'd10, 5'd2, 5'd11));
			send(reg_form(`OOO_OP_INTS, `OOO_FN_SRL, 5'd11, 5'd2, 5'd12));
		end
		drain();
		finish_test("dependent_chain", errs);
	endtask

	task automatic rename_pressure();
		int errs;
		errs = err_count;
		for (int i = 0; i < 40; i++)
			send(lit_form(`OOO_OP_INTA, `OOO_FN_ADDQ, 5'(i % 3 + 1), 8'(i),
				5'((i + 1) % 3 + 1)));
		drain();
		finish_test("rename_pressure", errs);
	endtask

	task automatic backpressure();
		int errs;
		int sent0;
		int commits0;
		errs = err_count;
		sent0 = sent_count;
		commits0 = commit_count;
		stall_count = 0;
		for (int i = 0; i < 24; i++)
			send(lit_form(`OOO_OP_INTA, `OOO_FN_ADDQ, 5'd5, 8'd1, 5'd5)); // Slow chain fills RS
		for (int i = 0; i < 20; i++)
			send(lit_form(`OOO_OP_INTL, `OOO_FN_BIS, 5'd31, rand_byte(), 5'(10 + i % 10)));
		drain();
		if (stall_count == 0) begin
			$display("inst_ready never dropped during the back-pressure test");
			err_count++;
		end
		if (commit_count - commits0 != sent_count - sent0) begin
			$display("ERR commit count: got %h expected %h", commit_count - commits0,
				sent_count - sent0);
			err_count++;
		end
		finish_test("backpressure", errs);
	endtask

	task automatic zero_register();
		int errs;
		errs = err_count;
		send(lit_form(`OOO_OP_INTL, `OOO_FN_BIS, 5'd31, 8'h55, 5'd20));
		send(lit_form(`OOO_OP_INTA, `OOO_FN_ADDQ, 5'd31, 8'h09, 5'd31));
		send(reg_form(`OOO_OP_INTL, `OOO_FN_BIS, 5'd31, 5'd31, 5'd20));
		send(lit_form(`OOO_OP_INTA, `OOO_FN_ADDQ, 5'd31, 8'h03, 5'd21));
		send(reg_form(`OOO_OP_INTA, `OOO_FN_ADDQ, 5'd31, 5'd31, 5'd22));
		send(reg_form(`OOO_OP_INTA, `OOO_FN_SUBQ, 5'd21, 5'd31, 5'd23));
		drain();
		finish_test("zero_register", errs);
	endtask

	task automatic halt_status();
		int errs;
		errs = err_count;
		apply_reset();
		send(lit_form(`OOO_OP_INTL, `OOO_FN_BIS, 5'd31, 8'h2a, 5'd1));
		send(reg_form(`OOO_OP_INTA, 7'h7f, 5'd1, 5'd2, 5'd3)); // Unknown INTA function
		drain();
		wait_status(`OOO_HALTED_ON_ILLEGAL);
		check_stalled();
		apply_reset();
		send('0);
		drain();
		wait_status(`OOO_HALTED_ON_HALT);
		check_stalled();
		finish_test("halt_status", errs);
	endtask

	initial begin
		seed = 32'hb28d_6772;
		err_count = 0;
		test_count = 0;
		sent_count = 0;
		commit_count = 0;
		stall_count = 0;
		reset = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		apply_reset();
		literal_loads();
		dependent_chain();
		rename_pressure();
		backpressure();
		zero_register();
		halt_status();
		$display("%0d tests, %0d dispatched, %0d committed, %0d errors", test_count,
			sent_count, commit_count, err_count);
		if (err_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+hdl
hdl/ooo_pkg.sv
hdl/decoder.sv
hdl/rename_unit.sv
hdl/rob.sv
hdl/reservation_station.sv
hdl/prf.sv
hdl/int_alu.sv
hdl/pipeline.sv
tb/pipeline_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module pipeline_tb \
	-Mdir obj_dir -o pipeline_sim
./obj_dir/pipeline_sim | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	exit 1
fi
